// ==== hw/lcd_bus_pkg.sv ====
package lcd_bus_pkg;

	// one byte on the d7..d0 pins
	typedef logic [7:0] lcd_byte_t;

	// {rs, data}, the unit handed from translator to bus engine
	typedef logic [8:0] lcd_word_t;

	// {lines, font, display on, cursor, blink, inc/dec, shift}
	typedef logic [6:0] lcd_config_t;

	// single-byte instructions
	localparam lcd_byte_t LCD_CLEAR_CODE = 8'h01;
	localparam lcd_byte_t LCD_HOME_CODE  = 8'h02;

	// instruction bases, low bits are filled from the configuration
	localparam lcd_byte_t LCD_ENTRY_MODE = 8'h04; // i/d in bit 1, s in bit 0
	localparam lcd_byte_t LCD_DISP_CTRL  = 8'h08; // d, c, b in bits 2..0
	localparam lcd_byte_t LCD_FUNC_SET   = 8'h30; // 8-bit bus, n and f in bits 3..2

	// set ddram address, address goes in bits 6..0
	localparam lcd_byte_t LCD_DDRAM_SET  = 8'h80;

	// first cell of the second line
	localparam lcd_byte_t LCD_LINE2_BASE = 8'h40;

	// visible cells per line
	localparam int LCD_COLS = 16;

	// Bit positions of the configuration word. The function set, display
	// control and entry mode instructions each take a slice of it.
	localparam int CFG_LINES  = 6;
	localparam int CFG_FONT   = 5;
	localparam int CFG_DISP   = 4;
	localparam int CFG_CURSOR = 3;
	localparam int CFG_BLINK  = 2;
	localparam int CFG_INC    = 1;
	localparam int CFG_SHIFT  = 0;

endpackage

// ==== hw/lcd_host_pkg.sv ====
package lcd_host_pkg;

	// commands a host may push
	typedef enum logic [1:0] {
		OP_PUT_CHAR = 2'd0, // arg is the character code
		OP_GOTO     = 2'd1, // arg holds row and column
		OP_CLEAR    = 2'd2, // arg ignored
		OP_HOME     = 2'd3  // arg ignored
	} host_op_t;

	// command argument
	typedef logic [7:0] host_arg_t;

	// go-to argument layout
	localparam int ARG_ROW_BIT = 4;
	localparam int ARG_COL_MSB = 3;

endpackage

// ==== hw/lcd_cmd_fifo.sv ====
module lcd_cmd_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmd_valid,
	input  lcd_host_pkg::host_op_t  cmd_op,
	input  lcd_host_pkg::host_arg_t cmd_arg,
	output logic                   credit_return,
	output logic                   q_valid,
	output lcd_host_pkg::host_op_t  q_op,
	output lcd_host_pkg::host_arg_t q_arg,
	input  logic                   q_ready
);
	import lcd_host_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	host_op_t   op_mem  [FIFO_DEPTH];
	host_arg_t  arg_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// circular pointer step
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// the host only sends while holding a credit, so there is always room
	assign push = cmd_valid;
	assign pop  = q_valid && q_ready;

	assign q_valid = (count != '0);
	assign q_op    = op_mem[rd_ptr];
	assign q_arg   = arg_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			op_mem[wr_ptr]  <= cmd_op;
			arg_mem[wr_ptr] <= cmd_arg;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop; // one credit back per released entry
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or simultaneous push and pop
			endcase
		end
	end

endmodule

// ==== hw/lcd_cmd_translate.sv ====
module lcd_cmd_translate (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    q_valid,
	input  lcd_host_pkg::host_op_t  q_op,
	input  lcd_host_pkg::host_arg_t q_arg,
	output logic                    q_ready,
	output logic                    w_valid,
	output lcd_bus_pkg::lcd_word_t  w_word,
	input  logic                    w_ready
);
	import lcd_host_pkg::*;
	import lcd_bus_pkg::*;

	localparam int COL_W = $clog2(LCD_COLS + 1);

	typedef enum logic [1:0] {
		IDLE, // waiting for a command
		WRAP, // line-change address out, character pending
		EMIT  // last word of the command out
	} state_t;

	state_t           state;
	logic             row;       // 0 = line 1, 1 = line 2
	logic [COL_W-1:0] col;       // reaches LCD_COLS after the last cell
	host_arg_t        pend_char; // character held over a wrap
	logic             accept;
	logic             at_eol;

	// set-ddram-address word for a cell
	function automatic lcd_word_t ddram_word(input logic r, input logic [3:0] c);
		lcd_byte_t base;
		base = r ? LCD_LINE2_BASE : 8'h00;
		return {1'b0, LCD_DDRAM_SET | (base + {4'b0000, c})};
	endfunction

	assign q_ready = (state == IDLE);
	assign w_valid = (state != IDLE);
	assign accept  = q_valid && q_ready;
	assign at_eol  = (col == COL_W'(LCD_COLS));

	// word register, held while the engine is not ready
	always_ff @(posedge clk) begin
		if (accept) begin
			pend_char <= q_arg;
			case (q_op)
				OP_PUT_CHAR: begin
					if (at_eol)
						w_word <= ddram_word(~row, 4'd0); // start of the other line
					else
						w_word <= {1'b1, q_arg};
				end
				OP_GOTO:  w_word <= ddram_word(q_arg[ARG_ROW_BIT], q_arg[ARG_COL_MSB:0]);
				OP_CLEAR: w_word <= {1'b0, LCD_CLEAR_CODE};
				default:  w_word <= {1'b0, LCD_HOME_CODE};
			endcase
		end else if (state == WRAP && w_ready) begin
			w_word <= {1'b1, pend_char}; // the character after the address
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			row   <= 1'b0;
			col   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						case (q_op)
							OP_PUT_CHAR: begin
								if (at_eol) begin
									state <= WRAP;
									row   <= ~row; // line 2 wraps back to line 1
									col   <= '0;
								end else begin
									state <= EMIT;
									col   <= col + 1'b1;
								end
							end
							OP_GOTO: begin
								state <= EMIT;
								row   <= q_arg[ARG_ROW_BIT];
								col   <= {1'b0, q_arg[ARG_COL_MSB:0]};
							end
							default: begin // clear and home
								state <= EMIT;
								row   <= 1'b0;
								col   <= '0;
							end
						endcase
					end
				end
				WRAP: begin
					if (w_ready) begin
						state <= EMIT;
						col   <= col + 1'b1; // pending char takes column 0
					end
				end
				EMIT: begin
					if (w_ready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== hw/lcd_bus_engine.sv ====
module lcd_bus_engine #(
	parameter int CLK_PER_US = 2
) (
	input  logic                     clk,
	input  logic                     rst,
	input  lcd_bus_pkg::lcd_config_t disp_config,
	input  logic                     w_valid,
	input  lcd_bus_pkg::lcd_word_t   w_word,
	output logic                     w_ready,
	output logic                     e,
	output logic                     rs,
	output lcd_bus_pkg::lcd_byte_t   lcd_data,
	output logic                     busy
);
	import lcd_bus_pkg::*;

	// all delays in clock cycles
	localparam int T_POWER_UP  = 500 * CLK_PER_US;
	localparam int T_STROBE    = 10 * CLK_PER_US;   // e width during init
	localparam int T_DISP_AT   = 60 * CLK_PER_US;   // function set + 50 us
	localparam int T_CLEAR_AT  = 120 * CLK_PER_US;  // display control + 50 us
	localparam int T_ENTRY_AT  = 330 * CLK_PER_US;  // clear + 200 us
	localparam int T_INIT_END  = 440 * CLK_PER_US;  // entry mode + 100 us
	localparam int T_E_RISE    = 1 * CLK_PER_US;
	localparam int T_E_FALL    = 14 * CLK_PER_US;
	localparam int T_SLOT      = 50 * CLK_PER_US;
	localparam int T_SLOT_LONG = 1600 * CLK_PER_US; // clear and home
	localparam int CNT_W       = $clog2(T_SLOT_LONG + 1);

	typedef enum logic [1:0] {
		POWER_UP,
		INIT,
		IDLE,
		XFER
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;
	logic [CNT_W-1:0] slot_end;
	logic             long_slot; // accepted word needs the long slot
	logic             accept;

	// {e, data} at a point of the init sequence
	// data stays on the pins through each wait so it is stable when e falls
	function automatic logic [8:0] init_out(input logic [CNT_W-1:0] t);
		lcd_byte_t code;
		logic      strobe;
		if (t < T_DISP_AT) begin
			code   = LCD_FUNC_SET | {4'b0000, disp_config[CFG_LINES:CFG_FONT], 2'b00};
			strobe = (t < T_STROBE);
		end else if (t < T_CLEAR_AT) begin
			code   = LCD_DISP_CTRL | {5'b00000, disp_config[CFG_DISP:CFG_BLINK]};
			strobe = (t < T_DISP_AT + T_STROBE);
		end else if (t < T_ENTRY_AT) begin
			code   = LCD_CLEAR_CODE;
			strobe = (t < T_CLEAR_AT + T_STROBE);
		end else begin
			code   = LCD_ENTRY_MODE | {6'b000000, disp_config[CFG_INC:CFG_SHIFT]};
			strobe = (t < T_ENTRY_AT + T_STROBE);
		end
		return {strobe, code};
	endfunction

	assign cnt_next = cnt + 1'b1;
	assign slot_end = long_slot ? CNT_W'(T_SLOT_LONG) : CNT_W'(T_SLOT);
	assign w_ready  = (state == IDLE);
	assign accept   = w_valid && w_ready;

	always_ff @(posedge clk) begin
		if (accept)
			long_slot <= !w_word[8] &&
				(w_word[7:0] == LCD_CLEAR_CODE || w_word[7:0] == LCD_HOME_CODE);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= POWER_UP;
			cnt      <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			lcd_data <= '0;
			busy     <= 1'b1;
		end else begin
			case (state)
				POWER_UP: begin
					if (cnt_next == CNT_W'(T_POWER_UP)) begin
						state         <= INIT;
						cnt           <= '0;
						{e, lcd_data} <= init_out('0); // function set starts right away
					end else begin
						cnt <= cnt_next;
					end
				end
				INIT: begin
					if (cnt_next == CNT_W'(T_INIT_END)) begin
						state    <= IDLE;
						cnt      <= '0;
						e        <= 1'b0;
						lcd_data <= '0;
						busy     <= 1'b0;
					end else begin
						cnt           <= cnt_next;
						{e, lcd_data} <= init_out(cnt_next);
					end
				end
				IDLE: begin
					if (accept) begin
						state    <= XFER;
						cnt      <= '0;
						rs       <= w_word[8];   // held for the whole slot
						lcd_data <= w_word[7:0];
						busy     <= 1'b1;
					end
				end
				XFER: begin
					if (cnt_next == slot_end) begin
						state    <= IDLE;
						cnt      <= '0;
						e        <= 1'b0;
						rs       <= 1'b0;
						lcd_data <= '0;
						busy     <= 1'b0;
					end else begin
						cnt <= cnt_next;
						e   <= (cnt_next >= CNT_W'(T_E_RISE)) && (cnt_next < CNT_W'(T_E_FALL));
					end
				end
				default: state <= POWER_UP;
			endcase
		end
	end

endmodule

// ==== hw/lcd_display_top.sv ====
module lcd_display_top #(
	parameter int CLK_PER_US = 2,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cmd_valid,
	input  lcd_host_pkg::host_op_t   cmd_op,
	input  lcd_host_pkg::host_arg_t  cmd_arg,
	output logic                     credit_return,
	input  lcd_bus_pkg::lcd_config_t disp_config,
	output logic                     e,
	output logic                     rs,
	output lcd_bus_pkg::lcd_byte_t   lcd_data,
	output logic                     busy
);
	import lcd_host_pkg::*;
	import lcd_bus_pkg::*;

	logic      q_valid;
	logic      q_ready;
	host_op_t  q_op;
	host_arg_t q_arg;
	logic      w_valid;
	logic      w_ready;
	lcd_word_t w_word;

	lcd_cmd_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_lcd_cmd_fifo (
		.clk           (clk),
		.rst           (rst),
		.cmd_valid     (cmd_valid),
		.cmd_op        (cmd_op),
		.cmd_arg       (cmd_arg),
		.credit_return (credit_return),
		.q_valid       (q_valid),
		.q_op          (q_op),
		.q_arg         (q_arg),
		.q_ready       (q_ready)
	);

	lcd_cmd_translate u_lcd_cmd_translate (
		.clk     (clk),
		.rst     (rst),
		.q_valid (q_valid),
		.q_op    (q_op),
		.q_arg   (q_arg),
		.q_ready (q_ready),
		.w_valid (w_valid),
		.w_word  (w_word),
		.w_ready (w_ready)
	);

	lcd_bus_engine #(
		.CLK_PER_US (CLK_PER_US)
	) u_lcd_bus_engine (
		.clk         (clk),
		.rst         (rst),
		.disp_config (disp_config),
		.w_valid     (w_valid),
		.w_word      (w_word),
		.w_ready     (w_ready),
		.e           (e),
		.rs          (rs),
		.lcd_data    (lcd_data),
		.busy        (busy)
	);

endmodule

// ==== tb/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk; // even duty cycle

endmodule

// ==== tb/tb_lcd_display.sv ====
module tb_lcd_display;
	timeunit 1ns;
	timeprecision 100ps;

	import lcd_host_pkg::*;
	import lcd_bus_pkg::*;

	localparam int CLK_PER_US = 2;
	localparam int FIFO_DEPTH = 4;
	localparam int RST_CYCLES = 16;
	localparam int DRIVE_DLY  = 2; // ns after the rising edge
	localparam int INIT_CYC   = 940 * CLK_PER_US;      // power-up wait plus init sequence
	localparam int SLOT_CYC   = 50 * CLK_PER_US + 4;   // slot plus handshake cycles
	localparam int LONG_CYC   = 1600 * CLK_PER_US + 4; // clear and home
	localparam int N_SHORT    = 95;                    // short words over all tests
	localparam int N_LONG     = 4;                     // clear and home words over all tests
	localparam int LIMIT      = RST_CYCLES + INIT_CYC + N_SHORT * SLOT_CYC
		+ N_LONG * LONG_CYC + 2000;

	logic        clk;
	logic        rst;
	logic        cmd_valid;
	host_op_t    cmd_op;
	host_arg_t   cmd_arg;
	logic        credit_return;
	lcd_config_t disp_config;
	logic        e;
	logic        rs;
	lcd_byte_t   lcd_data;
	logic        busy;

	lcd_word_t mon_q[$]; // words seen on the pins
	lcd_word_t exp_q[$]; // words the cursor model predicts
	int        credits = FIFO_DEPTH;
	int        min_credits;
	int        errors;
	int        checks;
	int        cycles;
	logic      model_row;
	int        model_col;

	tb_clock #(
		.PERIOD (20)
	) u_tb_clock (
		.clk (clk)
	);

	lcd_display_top #(
		.CLK_PER_US (CLK_PER_US),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_lcd_display_top (
		.clk           (clk),
		.rst           (rst),
		.cmd_valid     (cmd_valid),
		.cmd_op        (cmd_op),
		.cmd_arg       (cmd_arg),
		.credit_return (credit_return),
		.disp_config   (disp_config),
		.e             (e),
		.rs            (rs),
		.lcd_data      (lcd_data),
		.busy          (busy)
	);

	// bus monitor on the falling edge of e where the display latches
	always @(negedge e) begin
		if (!rst)
			mon_q.push_back({rs, lcd_data});
	end

	// host credit counter
	always @(posedge clk) begin
		if (!rst) begin
			if (cmd_valid && !credit_return)
				credits <= credits - 1;
			else if (!cmd_valid && credit_return)
				credits <= credits + 1;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: the tests did not finish within %0d cycles", LIMIT);
			$display("checks: %0d  errors: %0d", checks, errors);
			$display("Something failed");
			$finish;
		end
	end

	// set-address word for a cell
	function automatic lcd_word_t addr_word(input logic row, input int col);
		return {1'b0, 8'h80 | ((row ? 8'h40 : 8'h00) + 8'(col))};
	endfunction

	task automatic check_word(input string what, input lcd_word_t expected,
		input lcd_word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: %s expected rs=%b data=%h, got rs=%b data=%h",
				$time, what, expected[8], expected[7:0], actual[8], actual[7:0]);
		end
	endtask

	task automatic compare_words(input string test);
		int i;
		checks++;
		if (mon_q.size() != exp_q.size()) begin
			errors++;
			$display("ERROR at %0t: %s captured %0d words, expected %0d",
				$time, test, mon_q.size(), exp_q.size());
		end
		for (i = 0; i < exp_q.size() && i < mon_q.size(); i++)
			check_word($sformatf("%s word %0d", test, i), exp_q[i], mon_q[i]);
		mon_q.delete();
		exp_q.delete();
	endtask

	// all predicted words on the pins and the engine idle again
	task automatic wait_bus();
		do begin
			@(posedge clk);
			#DRIVE_DLY;
		end while (mon_q.size() < exp_q.size() || busy);
	endtask

	// one beat while a credit is held
	task automatic send_cmd(input host_op_t op, input host_arg_t arg);
		while (credits == 0) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		if (credits - 1 < min_credits)
			min_credits = credits - 1;
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_arg   = arg;
		@(posedge clk);
		#DRIVE_DLY;
		cmd_valid = 1'b0;
	endtask

	task automatic put_char(input host_arg_t c);
		if (model_col == LCD_COLS) begin // wrap first when past the last cell
			model_row = ~model_row;
			model_col = 0;
			exp_q.push_back(addr_word(model_row, 0));
		end
		exp_q.push_back({1'b1, c});
		model_col++;
		send_cmd(OP_PUT_CHAR, c);
	endtask

	task automatic goto_cell(input logic row, input logic [3:0] col);
		exp_q.push_back(addr_word(row, int'(col)));
		model_row = row;
		model_col = int'(col);
		send_cmd(OP_GOTO, {3'b000, row, col});
	endtask

	task automatic clear_display();
		exp_q.push_back({1'b0, 8'h01});
		model_row = 1'b0;
		model_col = 0;
		send_cmd(OP_CLEAR, 8'h00);
	endtask

	task automatic home_cursor();
		exp_q.push_back({1'b0, 8'h02});
		model_row = 1'b0;
		model_col = 0;
		send_cmd(OP_HOME, 8'h00);
	endtask

	function automatic host_arg_t rand_char();
		return host_arg_t'($urandom_range(8'h20, 8'h7e)); // printable ascii
	endfunction

	task automatic test_init();
		lcd_byte_t fs;
		lcd_byte_t dc;
		lcd_byte_t em;
		checks++;
		if (busy !== 1'b1) begin
			errors++;
			$display("ERROR at %0t: busy low before initialisation ended", $time);
		end
		fs = 8'h30 | {4'b0000, disp_config[6], disp_config[5], 2'b00}; // 8-bit, n, f
		dc = 8'h08 | {5'b00000, disp_config[4:2]};                     // d, c, b
		em = 8'h04 | {6'b000000, disp_config[1:0]};                    // i/d, s
		exp_q.push_back({1'b0, fs});
		exp_q.push_back({1'b0, dc});
		exp_q.push_back({1'b0, 8'h01});
		exp_q.push_back({1'b0, em});
		// the entry mode strobe ends 100 us before init is over
		while (mon_q.size() < exp_q.size()) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		checks++;
		if (busy !== 1'b1) begin
			errors++;
			$display("ERROR at %0t: busy fell before the init sequence ended", $time);
		end
		wait_bus();
		compare_words("init");
	endtask

	task automatic test_chars();
		repeat (8)
			put_char(rand_char());
		wait_bus();
		compare_words("chars");
	endtask

	task automatic test_goto();
		logic       row;
		logic [3:0] col;
		row = 1'($urandom_range(0, 1));
		col = 4'($urandom_range(0, 15));
		goto_cell(row, col);
		// run past the end of the line so the wrap shows where the cursor was
		repeat (LCD_COLS - int'(col) + 1)
			put_char(rand_char());
		wait_bus();
		compare_words("goto");
	endtask

	task automatic test_wrap();
		clear_display();
		repeat (17)
			put_char(rand_char());
		wait_bus();
		// clear, sixteen characters, then the line 2 address
		if (mon_q.size() > 17)
			check_word("wrap address", 9'h0c0, mon_q[17]);
		compare_words("wrap");
	endtask

	task automatic test_credits();
		home_cursor();
		min_credits = FIFO_DEPTH;
		repeat (12)
			put_char(rand_char());
		wait_bus();
		compare_words("credits");
		checks++;
		if (credits != FIFO_DEPTH) begin
			errors++;
			$display("ERROR at %0t: credit count %0d after burst, expected %0d",
				$time, credits, FIFO_DEPTH);
		end
		checks++;
		if (min_credits != 0) begin
			errors++;
			$display("ERROR at %0t: burst never used up the credits, lowest %0d",
				$time, min_credits);
		end
	endtask

	task automatic test_clear_home();
		goto_cell(1'($urandom_range(0, 1)), 4'($urandom_range(0, 15)));
		clear_display();
		repeat (17)
			put_char(rand_char());
		home_cursor();
		repeat (17)
			put_char(rand_char());
		wait_bus();
		// a wrap reaches line 2 only when the command left the cursor on line 1
		if (mon_q.size() > 37) begin
			check_word("wrap after clear", 9'h0c0, mon_q[18]);
			check_word("wrap after home", 9'h0c0, mon_q[37]);
		end
		compare_words("clear_home");
	endtask

	initial begin
		void'($urandom(35316));
		rst         = 1'b1;
		cmd_valid   = 1'b0;
		cmd_op      = OP_PUT_CHAR;
		cmd_arg     = '0;
		disp_config = lcd_config_t'($urandom());
		model_row   = 1'b0;
		model_col   = 0;
		min_credits = FIFO_DEPTH;
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;

		test_init();
		test_chars();
		test_goto();
		test_wrap();
		test_credits();
		test_clear_home();

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== files.f ====
hw/lcd_bus_pkg.sv
hw/lcd_host_pkg.sv
hw/lcd_cmd_fifo.sv
hw/lcd_cmd_translate.sv
hw/lcd_bus_engine.sv
hw/lcd_display_top.sv
tb/tb_clock.sv
tb/tb_lcd_display.sv
